// ==== hdl/aes_pkg.sv ====
// ============================================================
// Shared types, select encodings and the control word of the
// column-serial AES-128 core. Imported by every design module
// ============================================================
package aes_pkg;

	// Widths that carry a meaning
	typedef logic [7:0]   byte_t;
	typedef logic [31:0]  word_t;
	typedef logic [127:0] block_t;
	typedef logic [3:0]   round_t;

	typedef enum logic [1:0] {
		ENCRYPTION     = 2'b00,
		KEY_DERIVATION = 2'b01,
		DECRYPTION     = 2'b10,
		DECRYP_W_DERIV = 2'b11
	} op_mode_t;

	// ============================================================
	// Control FSM states
	// ============================================================
	typedef enum logic [3:0] {
		IDLE, ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3,
		ROUND_KEY0, ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3,
		READY, GEN_KEY0, GEN_KEY1, GEN_KEY2, GEN_KEY3, NOP
	} cu_state_t;

	// S-box bank source
	typedef enum logic [2:0] {
		COL_0 = 3'b000, COL_1 = 3'b001, COL_2 = 3'b010, COL_3 = 3'b011,
		G_FUNCTION = 3'b100
	} sbox_sel_t;

	// Add-round-key input: plain, feeding mix columns, or after it
	typedef enum logic [1:0] {COL, MIXCOL_IN, MIXCOL_OUT} rk_sel_t;

	// Column register write source
	typedef enum logic [1:0] {SHIFT_ROWS, ADD_RK_OUT, INPUT} col_sel_t;

	// Key register source on load
	localparam logic KEY_HOST = 1'b0;
	localparam logic KEY_OUT  = 1'b1;

	// One control word per cycle, control unit to datapath and key schedule
	typedef struct packed {
		sbox_sel_t  sbox_sel;
		rk_sel_t    rk_sel;
		col_sel_t   col_sel;
		logic [3:0] col_en;
		logic [3:0] key_en;
		logic [1:0] key_out_sel;
		logic       key_sel;
		logic       bypass_rk;
		logic       bypass_key_en;
		logic       load;
		logic       encrypt;
		round_t     round;
	} aes_ctrl_t;

	// Multiply by x in GF(2^8)
	function automatic byte_t xtime(byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	// Rcon for the key that follows round r
	function automatic byte_t rcon_f(round_t r);
		case (r)
			4'd0:    return 8'h01;
			4'd1:    return 8'h02;
			4'd2:    return 8'h04;
			4'd3:    return 8'h08;
			4'd4:    return 8'h10;
			4'd5:    return 8'h20;
			4'd6:    return 8'h40;
			4'd7:    return 8'h80;
			4'd8:    return 8'h1b;
			4'd9:    return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage

// ==== hdl/aes_sbox.sv ====
// ============================================================
// Byte S-box for both directions. Field inversion in GF(2^8)
// between the inverse affine map (decrypt) and the forward
// affine map (encrypt). Purely combinational
// ============================================================
`timescale 1ns/1ns

module aes_sbox
	import aes_pkg::*;
(
	input  byte_t in_byte,
	input  logic  inverse,
	output byte_t out_byte
);

	// Shift-and-add multiply, reduced by the AES polynomial
	function automatic byte_t gf_mul(byte_t a, byte_t b);
		byte_t p;
		byte_t x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = xtime(x);
		end
		return p;
	endfunction

	// a^254 as a^2 * a^4 * ... * a^128, zero maps to zero
	function automatic byte_t gf_inv(byte_t a);
		byte_t sq;
		byte_t acc;
		sq  = gf_mul(a, a);
		acc = sq;
		for (int i = 0; i < 6; i++)
		begin
			sq  = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	function automatic byte_t rotl8(byte_t a, int n);
		return byte_t'((a << n) | (a >> (8 - n)));
	endfunction

	byte_t pre_inv;
	byte_t inv_out;
	byte_t fwd_aff;

	// Inverse affine map undoes the forward one before inversion
	assign pre_inv = inverse ?
		(rotl8(in_byte, 1) ^ rotl8(in_byte, 3) ^ rotl8(in_byte, 6) ^ 8'h05) : in_byte;

	assign inv_out = gf_inv(pre_inv);

	// Forward affine map
	assign fwd_aff = inv_out ^ rotl8(inv_out, 1) ^ rotl8(inv_out, 2)
		^ rotl8(inv_out, 3) ^ rotl8(inv_out, 4) ^ 8'h63;

	assign out_byte = inverse ? inv_out : fwd_aff;

endmodule

// ==== hdl/control_unit.sv ====
// ============================================================
// Sequencer of the core. Column-serial round FSM with round
// counter, issuing one control word per cycle to datapath and
// key schedule, plus busy and the done pulse
// ============================================================
`timescale 1ns/1ns

module control_unit
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  op_mode_t  op_mode,
	input  logic      disable_core,
	output aes_ctrl_t ctrl,
	output logic      busy,
	output logic      done
);

	cu_state_t state, next_state;
	op_mode_t  op_q;
	round_t    rd_count;
	logic      rd_count_en;
	logic      accept;
	logic      enc;
	logic      first_round;
	logic      last_round;
	logic      gen_state;
	logic [1:0] col_idx;
	logic [1:0] end_col;

	// Start counts only when idle and not in the done cycle
	assign accept = start && !busy;
	assign busy   = (state != IDLE) || done;

	assign gen_state   = (state inside {GEN_KEY0, GEN_KEY1, GEN_KEY2, GEN_KEY3});
	assign enc         = (op_q == ENCRYPTION) || (op_q == KEY_DERIVATION) || gen_state;
	assign first_round = (rd_count == 4'd0);
	assign last_round  = (rd_count == 4'd10);
	// Last column of a round, column order follows direction
	assign end_col     = enc ? 2'd3 : 2'd0;

	// ============================================================
	// State, mode and done registers
	// ============================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			op_q  <= ENCRYPTION;
			done  <= 1'b0;
		end
		else
		begin
			state <= disable_core ? IDLE : next_state;
			// Abort in READY swallows the pulse
			done  <= (state == READY) && !disable_core;
			if (state == IDLE && accept)
				op_q <= op_mode;
		end
	end

	// Round counter, cleared between derivation and decryption
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= 4'd0;
		else if (state == IDLE || (state == GEN_KEY3 && last_round))
			rd_count <= 4'd0;
		else if (rd_count_en)
			rd_count <= rd_count + 4'd1;
	end

	// ============================================================
	// Next state
	// ============================================================
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (accept)
					case (op_mode)
						ENCRYPTION: next_state = ROUND0_COL0;
						DECRYPTION: next_state = ROUND0_COL3;
						default:    next_state = GEN_KEY0;
					endcase
			ROUND0_COL0: next_state = enc ? ROUND0_COL1 : ROUND_KEY0;
			ROUND0_COL1: next_state = enc ? ROUND0_COL2 : ROUND0_COL0;
			ROUND0_COL2: next_state = enc ? ROUND0_COL3 : ROUND0_COL1;
			ROUND0_COL3: next_state = enc ? ROUND_KEY0 : ROUND0_COL2;
			ROUND_KEY0:
				if (first_round)
					next_state = enc ? ROUND_COL0 : ROUND_COL3;
				else
					next_state = NOP;
			NOP:         next_state = enc ? ROUND_COL0 : ROUND_COL3;
			ROUND_COL0:  next_state = enc ? ROUND_COL1 : (last_round ? READY : ROUND_KEY0);
			ROUND_COL1:  next_state = enc ? ROUND_COL2 : ROUND_COL0;
			ROUND_COL2:  next_state = enc ? ROUND_COL3 : ROUND_COL1;
			ROUND_COL3:  next_state = enc ? (last_round ? READY : ROUND_KEY0) : ROUND_COL2;
			GEN_KEY0:    next_state = GEN_KEY1;
			GEN_KEY1:    next_state = GEN_KEY2;
			GEN_KEY2:    next_state = GEN_KEY3;
			GEN_KEY3:
				if (last_round)
					next_state = (op_q == KEY_DERIVATION) ? READY : ROUND0_COL3;
				else
					next_state = GEN_KEY0;
			default:     next_state = IDLE;
		endcase
	end

	// ============================================================
	// Control word
	// ============================================================
	always_comb
	begin
		ctrl               = '0;
		ctrl.sbox_sel      = COL_0;
		ctrl.rk_sel        = COL;
		ctrl.col_sel       = INPUT;
		ctrl.key_sel       = KEY_OUT;
		ctrl.encrypt       = enc;
		// Reverse schedule walks Rcon downwards
		ctrl.round         = enc ? rd_count : 4'd9 - rd_count;
		rd_count_en        = 1'b0;
		col_idx            = 2'd0;
		case (state)
			IDLE:
			begin
				ctrl.load    = accept;
				ctrl.key_sel = KEY_HOST;
			end
			// Initial add-round-key on raw columns
			ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3:
			begin
				col_idx          = 2'(state - ROUND0_COL0);
				ctrl.sbox_sel    = sbox_sel_t'({1'b0, col_idx});
				ctrl.key_out_sel = col_idx;
				ctrl.bypass_rk   = 1'b1;
				ctrl.col_sel     = ADD_RK_OUT;
				ctrl.col_en      = 4'b0001 << col_idx;
				if (col_idx == end_col)
				begin
					ctrl.col_sel = SHIFT_ROWS;
					ctrl.col_en  = 4'b1111;
				end
				// Decrypt steps the key back while it is consumed
				if (!enc && col_idx != 2'd0)
				begin
					ctrl.key_en        = 4'b0001 << col_idx;
					ctrl.bypass_key_en = 1'b1;
				end
			end
			ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
			begin
				col_idx          = 2'(state - ROUND_COL0);
				ctrl.sbox_sel    = sbox_sel_t'({1'b0, col_idx});
				ctrl.key_out_sel = col_idx;
				// No mix columns in the final round
				if (last_round)
					ctrl.rk_sel = COL;
				else
					ctrl.rk_sel = enc ? MIXCOL_OUT : MIXCOL_IN;
				ctrl.col_sel     = ADD_RK_OUT;
				ctrl.col_en      = 4'b0001 << col_idx;
				if (col_idx == end_col && !last_round)
				begin
					ctrl.col_sel = SHIFT_ROWS;
					ctrl.col_en  = 4'b1111;
				end
				ctrl.bypass_key_en = 1'b1;
				if (enc && col_idx != 2'd3)
					ctrl.key_en = 4'b0010 << col_idx;
				else if (!enc && col_idx != 2'd0 && !last_round)
					ctrl.key_en = 4'b0001 << col_idx;
			end
			// Word 0 through the g-function
			ROUND_KEY0, GEN_KEY0:
			begin
				ctrl.sbox_sel = G_FUNCTION;
				ctrl.key_en   = 4'b0001;
				rd_count_en   = 1'b1;
			end
			GEN_KEY1, GEN_KEY2, GEN_KEY3:
			begin
				ctrl.key_en        = 4'b0001 << (state - GEN_KEY0);
				ctrl.bypass_key_en = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

endmodule

// ==== hdl/aes_datapath.sv ====
// ============================================================
// State datapath. Four column registers, one column through
// the S-box bank, mix columns and add-round-key per cycle,
// shift rows across the whole state when selected
// ============================================================
`timescale 1ns/1ns

module aes_datapath
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  aes_ctrl_t ctrl,
	input  block_t    data_in,
	input  block_t    round_key,
	input  word_t     g_word,
	output word_t     sbox_word,
	output block_t    data_out
);

	word_t      col [4];
	word_t      stage [4];
	word_t      shifted [4];
	word_t      col_cur;
	word_t      sbox_in;
	word_t      base;
	word_t      rk_word;
	word_t      ark_out;
	logic [1:0] col_idx;
	logic       sbox_inv;

	// Forward or inverse mix of one column
	function automatic word_t mix_col(word_t w, logic inv);
		byte_t a0, a1, a2, a3, u, v, t;
		{a0, a1, a2, a3} = w;
		// Inverse as a pre-step followed by the forward matrix
		if (inv)
		begin
			u  = xtime(xtime(a0 ^ a2));
			v  = xtime(xtime(a1 ^ a3));
			a0 = a0 ^ u;
			a1 = a1 ^ v;
			a2 = a2 ^ u;
			a3 = a3 ^ v;
		end
		t = a0 ^ a1 ^ a2 ^ a3;
		return {a0 ^ t ^ xtime(a0 ^ a1), a1 ^ t ^ xtime(a1 ^ a2),
			a2 ^ t ^ xtime(a2 ^ a3), a3 ^ t ^ xtime(a3 ^ a0)};
	endfunction

	assign col_idx  = ctrl.sbox_sel[1:0];
	assign col_cur  = col[col_idx];
	assign sbox_in  = (ctrl.sbox_sel == G_FUNCTION) ? g_word : col_cur;
	// Key path always forward
	assign sbox_inv = !ctrl.encrypt && (ctrl.sbox_sel != G_FUNCTION);

	// ============================================================
	// S-box bank
	// ============================================================
	for (genvar b = 0; b < 4; b++)
	begin : g_sbox
		aes_sbox u_sbox (
			.in_byte  (sbox_in[8*b +: 8]),
			.inverse  (sbox_inv),
			.out_byte (sbox_word[8*b +: 8])
		);
	end

	assign base    = ctrl.bypass_rk ? col_cur : sbox_word;
	assign rk_word = round_key[127 - 32*ctrl.key_out_sel -: 32];

	// Add round key
	always_comb
	begin
		case (ctrl.rk_sel)
			MIXCOL_IN:  ark_out = mix_col(base ^ rk_word, !ctrl.encrypt);
			MIXCOL_OUT: ark_out = mix_col(base, !ctrl.encrypt) ^ rk_word;
			default:    ark_out = base ^ rk_word;
		endcase
	end

	// Shift rows over the state with the current column already updated
	always_comb
	begin
		for (int c = 0; c < 4; c++)
			stage[c] = (c == int'(col_idx)) ? ark_out : col[c];
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				if (ctrl.encrypt)
					shifted[c][31 - 8*r -: 8] = stage[(c + r) % 4][31 - 8*r -: 8];
				else
					shifted[c][31 - 8*r -: 8] = stage[(c + 4 - r) % 4][31 - 8*r -: 8];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 4; i++)
				col[i] <= '0;
		end
		else if (ctrl.load)
		begin
			for (int i = 0; i < 4; i++)
				col[i] <= data_in[127 - 32*i -: 32];
		end
		else
		begin
			for (int i = 0; i < 4; i++)
				if (ctrl.col_en[i])
					case (ctrl.col_sel)
						SHIFT_ROWS: col[i] <= shifted[i];
						ADD_RK_OUT: col[i] <= ark_out;
						default:    col[i] <= data_in[127 - 32*i -: 32];
					endcase
		end
	end

	assign data_out = {col[0], col[1], col[2], col[3]};

endmodule

// ==== hdl/key_schedule.sv ====
// ============================================================
// Key schedule with four word registers. Steps forward for
// encryption and derivation, backward for decryption, one word
// per enabled cycle. Word 0 uses the shared S-box bank
// ============================================================
`timescale 1ns/1ns

module key_schedule
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  aes_ctrl_t ctrl,
	input  block_t    key_in,
	input  word_t     sbox_word,
	output block_t    round_key,
	output word_t     g_word,
	output block_t    key_out
);

	word_t key_w [4];
	word_t g_term;

	// RotWord of the last word, substituted in the datapath bank
	assign g_word = {key_w[3][23:0], key_w[3][31:24]};
	assign g_term = sbox_word ^ {rcon_f(ctrl.round), 24'h000000};

	// ============================================================
	// Word update
	// ============================================================
	// Both directions share one update rule
	//   forward:  w[i] ^= w[i-1] (new), w[0] ^= g(w[3])
	//   reverse:  w[3..1] first, then w[0] with the recovered w[3]
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 4; i++)
				key_w[i] <= '0;
		end
		else if (ctrl.load && ctrl.key_sel == KEY_HOST)
		begin
			for (int i = 0; i < 4; i++)
				key_w[i] <= key_in[127 - 32*i -: 32];
		end
		else
		begin
			for (int i = 0; i < 4; i++)
				if (ctrl.key_en[i])
				begin
					// Neighbour chain, or the g-function term
					if (ctrl.bypass_key_en)
						key_w[i] <= key_w[i] ^ key_w[(i + 3) % 4];
					else
						key_w[i] <= key_w[i] ^ g_term;
				end
		end
	end

	assign round_key = {key_w[0], key_w[1], key_w[2], key_w[3]};
	assign key_out   = round_key;

endmodule

// ==== hdl/aes_core.sv ====
// ============================================================
// AES-128 ECB core top. Start pulse in, done pulse out,
// disable_core aborts. Control drives datapath and key schedule
// ============================================================
`timescale 1ns/1ns

module aes_core
	import aes_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	input  op_mode_t op_mode,
	input  logic     disable_core,
	input  block_t   data_in,
	input  block_t   key_in,
	output block_t   data_out,
	output block_t   key_out,
	output logic     busy,
	output logic     done
);

	aes_ctrl_t ctrl;
	block_t    round_key;
	word_t     g_word;
	word_t     sbox_word;

	// Sequencer
	control_unit u_control_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.op_mode      (op_mode),
		.disable_core (disable_core),
		.ctrl         (ctrl),
		.busy         (busy),
		.done         (done)
	);

	// State columns and shared S-box bank
	aes_datapath u_aes_datapath (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.data_in   (data_in),
		.round_key (round_key),
		.g_word    (g_word),
		.sbox_word (sbox_word),
		.data_out  (data_out)
	);

	// Round keys
	key_schedule u_key_schedule (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.key_in    (key_in),
		.sbox_word (sbox_word),
		.round_key (round_key),
		.g_word    (g_word),
		.key_out   (key_out)
	);

endmodule

// ==== dv/aes_core_assertions.sv ====
// ============================================================
// Protocol checker for the AES core. Bound into aes_core and
// watches start, busy, done, abort and the control word
// ============================================================
`timescale 1ns/1ns

module aes_core_assertions
	import aes_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      start,
	input logic      disable_core,
	input logic      busy,
	input logic      done,
	input aes_ctrl_t ctrl,
	input cu_state_t state
);

	// Count of failed assertions
	int   fail_count = 0;
	// An accepted start still waiting for its done
	logic pending;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pending <= 1'b0;
		else if (done || disable_core)
			pending <= 1'b0;
		else if (start && !busy)
			pending <= 1'b1;
	end

	// ============================================================
	// Done and busy
	// ============================================================
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
	else
	begin
		$error("done stayed high for more than one cycle");
		fail_count++;
	end

	// The done cycle follows a busy cycle
	done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
	else
	begin
		$error("done pulse without a busy operation before it");
		fail_count++;
	end

	// Reset values of busy and done
	reset_quiet: assert property (@(posedge clk) !rst_n |-> (!busy && !done))
	else
	begin
		$error("busy or done high during reset");
		fail_count++;
	end

	// ============================================================
	// Start handling
	// ============================================================
	// No done without an accepted start, so a start while busy adds none
	done_per_start: assert property (@(posedge clk) disable iff (!rst_n) done |-> pending)
	else
	begin
		$error("done without an outstanding accepted start");
		fail_count++;
	end

	abort_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
		disable_core |=> (state == IDLE && !done))
	else
	begin
		$error("disable_core did not return the FSM to IDLE quietly");
		fail_count++;
	end

	idle_no_enables: assert property (@(posedge clk) disable iff (!rst_n)
		(state == IDLE) |-> (ctrl.col_en == 4'b0000 && ctrl.key_en == 4'b0000))
	else
	begin
		$error("column or key enables active in IDLE");
		fail_count++;
	end

endmodule

// Attach to every aes_core, FSM state taken from the control unit
bind aes_core aes_core_assertions u_assertions (
	.clk          (clk),
	.rst_n        (rst_n),
	.start        (start),
	.disable_core (disable_core),
	.busy         (busy),
	.done         (done),
	.ctrl         (ctrl),
	.state        (u_control_unit.state)
);

// ==== dv/tb_aes_core.sv ====
// ============================================================
// Testbench for the AES-128 core. FIPS-197 known answers,
// random round trips, abort and start-while-busy stimulus
// ============================================================
`timescale 1ns/1ns

module tb_aes_core
	import aes_pkg::*;
();

	// FIPS-197 appendix C.1 vectors
	localparam block_t FIPS_KEY      = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t FIPS_PT       = 128'h00112233445566778899aabbccddeeff;
	localparam block_t FIPS_CT       = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam block_t FIPS_LAST_KEY = 128'h13111d7fe3944a17f307a78b4d2b30c5;

	// Run length: 12 operations, each well under 160 cycles
	localparam int RESET_CYCLES   = 16;
	localparam int NUM_OPS        = 12;
	localparam int OP_CYCLES      = 160;
	localparam int WATCH_CYCLES   = 150;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * OP_CYCLES + WATCH_CYCLES;

	logic     clk;
	logic     rst_n;
	logic     start;
	op_mode_t op_mode;
	logic     disable_core;
	block_t   data_in;
	block_t   key_in;
	block_t   data_out;
	block_t   key_out;
	logic     busy;
	logic     done;

	int       errors = 0;
	int       total;
	int       cycles = 0;
	int       seed = 61837;
	block_t   rand_key;
	block_t   rand_pt;
	block_t   rand_ct;
	block_t   junk;

	aes_core DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.op_mode      (op_mode),
		.disable_core (disable_core),
		.data_in      (data_in),
		.key_in       (key_in),
		.data_out     (data_out),
		.key_out      (key_out),
		.busy         (busy),
		.done         (done)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: no finish within %0d cycles, an operation hung", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================
	// One-cycle start with operands, accepted or not
	task automatic pulse_start(input op_mode_t op, input block_t din, input block_t kin);
		@(posedge clk);
		start   <= 1'b1;
		op_mode <= op;
		data_in <= din;
		key_in  <= kin;
		@(posedge clk);
		start   <= 1'b0;
	endtask

	// Wait until idle, then start
	task automatic start_op(input op_mode_t op, input block_t din, input block_t kin);
		@(negedge clk);
		while (busy)
			@(negedge clk);
		pulse_start(op, din, kin);
	endtask

	// Returns at the falling edge of the done cycle
	task automatic wait_done();
		@(negedge clk);
		while (!done)
			@(negedge clk);
	endtask

	task automatic compare_block(input string name, input block_t got, input block_t exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic random_block(output block_t b);
		b = {$random(seed), $random(seed), $random(seed), $random(seed)};
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	initial
	begin
		rst_n        = 1'b0;
		start        = 1'b0;
		op_mode      = ENCRYPTION;
		disable_core = 1'b0;
		data_in      = '0;
		key_in       = '0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;

		// Known answers
		start_op(ENCRYPTION, FIPS_PT, FIPS_KEY);
		wait_done();
		compare_block("data_out", data_out, FIPS_CT);

		start_op(KEY_DERIVATION, FIPS_PT, FIPS_KEY);
		wait_done();
		compare_block("key_out", key_out, FIPS_LAST_KEY);

		start_op(DECRYP_W_DERIV, FIPS_CT, FIPS_KEY);
		wait_done();
		compare_block("data_out", data_out, FIPS_PT);

		// Host supplies the final round key
		start_op(DECRYPTION, FIPS_CT, FIPS_LAST_KEY);
		wait_done();
		compare_block("data_out", data_out, FIPS_PT);

		// Random round trips under one key
		random_block(rand_key);
		for (int i = 0; i < 3; i++)
		begin
			random_block(rand_pt);
			start_op(ENCRYPTION, rand_pt, rand_key);
			wait_done();
			rand_ct = data_out;
			start_op(DECRYP_W_DERIV, rand_ct, rand_key);
			wait_done();
			compare_block("data_out", data_out, rand_pt);
		end

		// Abort mid encryption
		start_op(ENCRYPTION, FIPS_PT, FIPS_KEY);
		repeat (20)
			@(negedge clk);
		@(posedge clk);
		disable_core <= 1'b1;
		@(posedge clk);
		disable_core <= 1'b0;
		@(negedge clk);
		assert (!busy)
		else
		begin
			errors++;
			$display("busy stayed high after disable_core aborted the operation");
		end
		repeat (WATCH_CYCLES)
		begin
			@(negedge clk);
			assert (!done)
			else
			begin
				errors++;
				$display("a done pulse appeared for the aborted operation");
			end
		end

		// Second start while busy must not disturb the first
		random_block(junk);
		start_op(ENCRYPTION, FIPS_PT, FIPS_KEY);
		repeat (5)
			@(posedge clk);
		pulse_start(DECRYPTION, junk, junk);
		wait_done();
		compare_block("data_out", data_out, FIPS_CT);

		repeat (8)
			@(posedge clk);
		total = errors + DUT.u_assertions.fail_count;
		$display("Errors: %0d total, %0d in checks, %0d in assertions",
			total, errors, DUT.u_assertions.fail_count);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/aes_pkg.sv
hdl/aes_sbox.sv
hdl/control_unit.sv
hdl/aes_datapath.sv
hdl/key_schedule.sv
hdl/aes_core.sv
dv/aes_core_assertions.sv
dv/tb_aes_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_aes_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
